// File: logic/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Datapath widths
`define CORE_ADDR_W 32
`define CORE_WORD_W 32
`define CORE_LINE_W 64 // One response half, two halves per line

// L1.5 field widths
`define CORE_RQTYPE_W 5
`define CORE_RTYPE_W 4
`define CORE_SIZE_BITS 3

// Request size codes
`define CORE_SIZE_B 3'd0
`define CORE_SIZE_H 3'd1
`define CORE_SIZE_W 3'd2
`define CORE_SIZE_LINE 3'd4 // Full 16 byte line, fetch only

`endif

// File: logic/core_pkg.sv
`include "core_macros.svh"

package core_pkg;

	// L1.5 request types, OpenPiton encoding
	typedef enum logic [`CORE_RQTYPE_W-1:0] {
		rq_load = 5'b00000,
		rq_store = 5'b00001,
		rq_ifill = 5'b10000
	} l15_rqtype_e;

	// Response return types
	typedef enum logic [`CORE_RTYPE_W-1:0] {
		rt_load_ret = 4'b0000,
		rt_ifill_ret = 4'b0001,
		rt_st_ack = 4'b0100
	} l15_rtype_e;

	// Core side memory ops
	typedef enum logic [3:0] {
		mem_none, mem_lb, mem_lh, mem_lw, mem_lbu, mem_lhu,
		mem_sb, mem_sh, mem_sw
	} mem_op_e;

	// Cache port owner
	typedef enum logic [1:0] {
		arb_instr, // Fetch owns the port
		arb_wait, // Draining the fill response
		arb_mem // LSU owns the port
	} arb_state_e;

	typedef enum logic [1:0] {fetch_idle, fetch_req, fetch_wait} fetch_state_e;

	typedef enum logic [1:0] {lsu_idle, lsu_req, lsu_wait, lsu_resp} lsu_state_e;

	// LSU result as held for the core
	typedef struct packed {
		logic [`CORE_WORD_W-1:0] rdata;
		logic err; // Misaligned access
	} lsu_resp_t;

endpackage

// File: logic/l15_if.sv
`include "core_macros.svh"

interface l15_if;

	// Request channel
	core_pkg::l15_rqtype_e rqtype;
	logic [`CORE_SIZE_BITS-1:0] size;
	logic [`CORE_ADDR_W-1:0] address;
	logic [`CORE_WORD_W-1:0] data; // Store data, lane replicated
	logic val;
	logic ack; // Request taken

	// Response channel
	logic resp_val;
	logic [`CORE_LINE_W-1:0] data_0;
	logic [`CORE_LINE_W-1:0] data_1;
	core_pkg::l15_rtype_e returntype;
	logic req_ack; // Response taken

	modport requester (
		output rqtype, size, address, data, val, req_ack,
		input ack, resp_val, data_0, data_1, returntype
	);

	modport arbiter (
		input rqtype, size, address, data, val, req_ack,
		output ack, resp_val, data_0, data_1, returntype
	);

endinterface

// File: logic/fetch_unit.sv
`include "core_macros.svh"

module fetch_unit (
	input logic clk,
	input logic nrst,
	input logic fetch_valid,
	input logic [`CORE_ADDR_W-1:0] fetch_addr,
	output logic fetch_ready,
	output logic instr_valid,
	output logic [`CORE_WORD_W-1:0] instr,
	input logic instr_ready,
	l15_if.requester l15
);

	core_pkg::fetch_state_e state;
	logic [`CORE_ADDR_W-1:0] addr_q; // Fetch address under service
	logic [`CORE_WORD_W-1:0] word_sel;
	logic fill_fire;

	// New fetch only once the last instr has left
	assign fetch_ready = (state == core_pkg::fetch_idle) && !instr_valid;

	// Whole line request at the aligned address
	assign l15.rqtype = core_pkg::rq_ifill;
	assign l15.size = `CORE_SIZE_LINE;
	assign l15.address = {addr_q[`CORE_ADDR_W-1:4], 4'b0000};
	assign l15.data = '0; // Unused for fills
	assign l15.val = (state == core_pkg::fetch_req);

	// Fill taken as soon as it shows up
	assign l15.req_ack = (state == core_pkg::fetch_wait) && l15.resp_val &&
		(l15.returntype == core_pkg::rt_ifill_ret);
	assign fill_fire = l15.req_ack;

	// Word k of the line, data_0 holds words 0 and 1
	always_comb
	begin
		case (addr_q[3:2])
			2'd0: word_sel = l15.data_0[31:0];
			2'd1: word_sel = l15.data_0[63:32];
			2'd2: word_sel = l15.data_1[31:0];
			default: word_sel = l15.data_1[63:32];
		endcase
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			state <= core_pkg::fetch_idle;
			instr_valid <= 1'b0;
		end
		else
		begin
			case (state)
				core_pkg::fetch_idle:
					if (fetch_valid && fetch_ready)
						state <= core_pkg::fetch_req; // Request goes out next cycle
				core_pkg::fetch_req:
					if (l15.ack)
						state <= core_pkg::fetch_wait;
				default:
					if (fill_fire)
						state <= core_pkg::fetch_idle;
			endcase
			if (fill_fire)
				instr_valid <= 1'b1;
			else if (instr_ready)
				instr_valid <= 1'b0; // Instr transfer
		end
	end

	// Address and word, no reset needed
	always_ff @(posedge clk)
	begin
		if (fetch_valid && fetch_ready)
			addr_q <= fetch_addr;
		if (fill_fire)
			instr <= word_sel; // Held until instr_ready
	end

endmodule

// File: logic/lsu.sv
`include "core_macros.svh"

module lsu (
	input logic clk,
	input logic nrst,
	input logic lsu_cmd_valid,
	input core_pkg::mem_op_e lsu_cmd_op,
	input logic [`CORE_ADDR_W-1:0] lsu_cmd_addr,
	input logic [`CORE_WORD_W-1:0] lsu_cmd_wdata,
	output logic lsu_cmd_ready,
	output logic lsu_resp_valid,
	output logic [`CORE_WORD_W-1:0] lsu_resp_rdata,
	output logic lsu_resp_err,
	input logic lsu_resp_ready,
	l15_if.requester l15
);

	core_pkg::lsu_state_e state;
	core_pkg::mem_op_e op_q;
	logic [`CORE_ADDR_W-1:0] addr_q;
	logic [`CORE_WORD_W-1:0] wdata_q;
	core_pkg::lsu_resp_t resp_q;
	logic cmd_fire;
	logic misaligned;
	logic skip_port; // Done without the cache
	logic is_store;
	logic [`CORE_WORD_W-1:0] word;
	logic [7:0] byte_lane;
	logic [15:0] half_lane;
	logic [`CORE_WORD_W-1:0] load_data;

	assign cmd_fire = lsu_cmd_valid && lsu_cmd_ready;
	assign lsu_cmd_ready = (state == core_pkg::lsu_idle);
	assign lsu_resp_valid = (state == core_pkg::lsu_resp);
	assign lsu_resp_rdata = resp_q.rdata;
	assign lsu_resp_err = resp_q.err;

	// Alignment on the incoming command
	always_comb
	begin
		case (lsu_cmd_op)
			core_pkg::mem_lh, core_pkg::mem_lhu, core_pkg::mem_sh:
				misaligned = lsu_cmd_addr[0];
			core_pkg::mem_lw, core_pkg::mem_sw:
				misaligned = |lsu_cmd_addr[1:0];
			default: misaligned = 1'b0; // Bytes always fit
		endcase
	end
	assign skip_port = misaligned || (lsu_cmd_op == core_pkg::mem_none);

	// Request type, size and lane replicated store data
	always_comb
	begin
		is_store = 1'b0;
		l15.size = `CORE_SIZE_W;
		l15.data = wdata_q;
		case (op_q)
			core_pkg::mem_lb, core_pkg::mem_lbu: l15.size = `CORE_SIZE_B;
			core_pkg::mem_lh, core_pkg::mem_lhu: l15.size = `CORE_SIZE_H;
			core_pkg::mem_sb:
			begin
				is_store = 1'b1;
				l15.size = `CORE_SIZE_B;
				l15.data = {4{wdata_q[7:0]}};
			end
			core_pkg::mem_sh:
			begin
				is_store = 1'b1;
				l15.size = `CORE_SIZE_H;
				l15.data = {2{wdata_q[15:0]}};
			end
			core_pkg::mem_sw: is_store = 1'b1;
			default: ;
		endcase
	end
	assign l15.rqtype = is_store ? core_pkg::rq_store : core_pkg::rq_load;
	assign l15.address = addr_q;
	assign l15.val = (state == core_pkg::lsu_req);
	assign l15.req_ack = (state == core_pkg::lsu_wait) && l15.resp_val;

	// Word of the line, then the lane inside it
	always_comb
	begin
		case (addr_q[3:2])
			2'd0: word = l15.data_0[31:0];
			2'd1: word = l15.data_0[63:32];
			2'd2: word = l15.data_1[31:0];
			default: word = l15.data_1[63:32];
		endcase
		byte_lane = word[8*addr_q[1:0] +: 8];
		half_lane = addr_q[1] ? word[31:16] : word[15:0];
		case (op_q)
			core_pkg::mem_lb: load_data = {{24{byte_lane[7]}}, byte_lane};
			core_pkg::mem_lbu: load_data = {24'd0, byte_lane};
			core_pkg::mem_lh: load_data = {{16{half_lane[15]}}, half_lane};
			core_pkg::mem_lhu: load_data = {16'd0, half_lane};
			core_pkg::mem_lw: load_data = word;
			default: load_data = '0; // Stores give zero
		endcase
		if (l15.returntype != core_pkg::rt_load_ret)
			load_data = '0; // Store ack carries no data
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			state <= core_pkg::lsu_idle;
		else
		begin
			case (state)
				core_pkg::lsu_idle:
					if (cmd_fire)
						state <= skip_port ? core_pkg::lsu_resp : core_pkg::lsu_req;
				core_pkg::lsu_req:
					if (l15.ack)
						state <= core_pkg::lsu_wait;
				core_pkg::lsu_wait:
					if (l15.req_ack)
						state <= core_pkg::lsu_resp;
				default:
					if (lsu_resp_ready)
						state <= core_pkg::lsu_idle;
			endcase
		end
	end

	// Command and result payload
	always_ff @(posedge clk)
	begin
		if (cmd_fire)
		begin
			op_q <= lsu_cmd_op;
			addr_q <= lsu_cmd_addr;
			wdata_q <= lsu_cmd_wdata;
			resp_q.rdata <= '0;
			resp_q.err <= misaligned;
		end
		else if (l15.req_ack)
		begin
			resp_q.rdata <= load_data;
			resp_q.err <= 1'b0;
		end
	end

endmodule

// File: logic/l15_arbiter.sv
`include "core_macros.svh"

module l15_arbiter (
	input logic clk,
	input logic nrst,
	l15_if.arbiter fetch,
	l15_if.arbiter mem,
	output logic [`CORE_RQTYPE_W-1:0] l15_rqtype,
	output logic [`CORE_SIZE_BITS-1:0] l15_size,
	output logic [`CORE_ADDR_W-1:0] l15_address,
	output logic [`CORE_WORD_W-1:0] l15_data,
	output logic l15_val,
	input logic l15_ack,
	input logic l15_resp_val,
	input logic [`CORE_LINE_W-1:0] l15_data_0,
	input logic [`CORE_LINE_W-1:0] l15_data_1,
	input logic [`CORE_RTYPE_W-1:0] l15_returntype,
	output logic l15_req_ack
);

	core_pkg::arb_state_e state;
	core_pkg::arb_state_e state_next;
	logic fill_out; // Fill sent, response not yet taken
	logic fill_next;
	logic fetch_req_fire;
	logic fetch_resp_fire;
	logic mem_resp_fire;

	assign fetch_req_fire = (state == core_pkg::arb_instr) && fetch.val && l15_ack;
	assign fetch_resp_fire = fetch.resp_val && fetch.req_ack;
	assign mem_resp_fire = mem.resp_val && mem.req_ack;
	assign fill_next = fetch_req_fire || (fill_out && !fetch_resp_fire);

	// Response payload goes to both, resp_val picks the owner
	assign fetch.data_0 = l15_data_0;
	assign fetch.data_1 = l15_data_1;
	assign fetch.returntype = core_pkg::l15_rtype_e'(l15_returntype);
	assign mem.data_0 = l15_data_0;
	assign mem.data_1 = l15_data_1;
	assign mem.returntype = core_pkg::l15_rtype_e'(l15_returntype);

	always_comb
	begin
		// Fetch fields parked on the port, nothing valid
		l15_rqtype = fetch.rqtype;
		l15_size = fetch.size;
		l15_address = fetch.address;
		l15_data = fetch.data;
		l15_val = 1'b0;
		l15_req_ack = 1'b0;
		fetch.ack = 1'b0;
		fetch.resp_val = 1'b0;
		mem.ack = 1'b0;
		mem.resp_val = 1'b0;
		case (state)
			core_pkg::arb_instr:
			begin
				l15_val = fetch.val;
				fetch.ack = l15_ack;
				fetch.resp_val = l15_resp_val;
				l15_req_ack = fetch.req_ack;
			end
			core_pkg::arb_wait:
			begin
				// No request acks, only the fill drains
				fetch.resp_val = l15_resp_val;
				l15_req_ack = fetch.req_ack;
			end
			default:
			begin
				l15_rqtype = mem.rqtype;
				l15_size = mem.size;
				l15_address = mem.address;
				l15_data = mem.data;
				l15_val = mem.val;
				mem.ack = l15_ack;
				mem.resp_val = l15_resp_val;
				l15_req_ack = mem.req_ack;
			end
		endcase
	end

	// Next owner
	always_comb
	begin
		state_next = state;
		case (state)
			core_pkg::arb_instr:
				if (mem.val)
					state_next = fill_next ? core_pkg::arb_wait : core_pkg::arb_mem;
			core_pkg::arb_wait:
				if (fetch_resp_fire)
					state_next = core_pkg::arb_mem;
			default:
				if (mem_resp_fire)
					state_next = core_pkg::arb_instr; // Back to fetch
		endcase
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			state <= core_pkg::arb_instr;
			fill_out <= 1'b0;
		end
		else
		begin
			state <= state_next;
			fill_out <= fill_next;
		end
	end

endmodule

// File: logic/core_mem_top.sv
`include "core_macros.svh"

module core_mem_top (
	input logic clk,
	input logic nrst,
	// Fetch side
	input logic fetch_valid,
	input logic [`CORE_ADDR_W-1:0] fetch_addr,
	output logic fetch_ready,
	output logic instr_valid,
	output logic [`CORE_WORD_W-1:0] instr,
	input logic instr_ready,
	// Load/store side
	input logic lsu_cmd_valid,
	input core_pkg::mem_op_e lsu_cmd_op,
	input logic [`CORE_ADDR_W-1:0] lsu_cmd_addr,
	input logic [`CORE_WORD_W-1:0] lsu_cmd_wdata,
	output logic lsu_cmd_ready,
	output logic lsu_resp_valid,
	output logic [`CORE_WORD_W-1:0] lsu_resp_rdata,
	output logic lsu_resp_err,
	input logic lsu_resp_ready,
	// Single L1.5 port
	output logic [`CORE_RQTYPE_W-1:0] l15_rqtype,
	output logic [`CORE_SIZE_BITS-1:0] l15_size,
	output logic [`CORE_ADDR_W-1:0] l15_address,
	output logic [`CORE_WORD_W-1:0] l15_data,
	output logic l15_val,
	input logic l15_ack,
	input logic l15_resp_val,
	input logic [`CORE_LINE_W-1:0] l15_data_0,
	input logic [`CORE_LINE_W-1:0] l15_data_1,
	input logic [`CORE_RTYPE_W-1:0] l15_returntype,
	output logic l15_req_ack
);

	l15_if fetch_l15 ();
	l15_if mem_l15 ();

	fetch_unit fetch_unit_inst (
		.clk (clk),
		.nrst (nrst),
		.fetch_valid (fetch_valid),
		.fetch_addr (fetch_addr),
		.fetch_ready (fetch_ready),
		.instr_valid (instr_valid),
		.instr (instr),
		.instr_ready (instr_ready),
		.l15 (fetch_l15.requester)
	);

	lsu lsu_inst (
		.clk (clk),
		.nrst (nrst),
		.lsu_cmd_valid (lsu_cmd_valid),
		.lsu_cmd_op (lsu_cmd_op),
		.lsu_cmd_addr (lsu_cmd_addr),
		.lsu_cmd_wdata (lsu_cmd_wdata),
		.lsu_cmd_ready (lsu_cmd_ready),
		.lsu_resp_valid (lsu_resp_valid),
		.lsu_resp_rdata (lsu_resp_rdata),
		.lsu_resp_err (lsu_resp_err),
		.lsu_resp_ready (lsu_resp_ready),
		.l15 (mem_l15.requester)
	);

	// Shares the one cache port
	l15_arbiter l15_arbiter_inst (
		.clk (clk),
		.nrst (nrst),
		.fetch (fetch_l15.arbiter),
		.mem (mem_l15.arbiter),
		.l15_rqtype (l15_rqtype),
		.l15_size (l15_size),
		.l15_address (l15_address),
		.l15_data (l15_data),
		.l15_val (l15_val),
		.l15_ack (l15_ack),
		.l15_resp_val (l15_resp_val),
		.l15_data_0 (l15_data_0),
		.l15_data_1 (l15_data_1),
		.l15_returntype (l15_returntype),
		.l15_req_ack (l15_req_ack)
	);

endmodule

// File: sim/l15_model.sv
`include "core_macros.svh"

module l15_model (
	input logic clk,
	input logic nrst,
	input logic [31:0] rnd, // Random word, new every cycle
	input logic [`CORE_RQTYPE_W-1:0] l15_rqtype,
	input logic [`CORE_SIZE_BITS-1:0] l15_size,
	input logic [`CORE_ADDR_W-1:0] l15_address,
	input logic [`CORE_WORD_W-1:0] l15_data,
	input logic l15_val,
	output logic l15_ack,
	output logic l15_resp_val,
	output logic [`CORE_LINE_W-1:0] l15_data_0,
	output logic [`CORE_LINE_W-1:0] l15_data_1,
	output logic [`CORE_RTYPE_W-1:0] l15_returntype,
	input logic l15_req_ack,
	output int req_count // Requests taken since reset
);

	logic [31:0] mem [0:255]; // 1 KB, address bits 9:2
	logic busy; // Request taken, response not yet accepted
	logic [1:0] ack_wait; // Cycles left before the next ack
	logic [1:0] resp_wait;
	logic [7:0] widx;
	logic [7:0] lidx; // First word of the line

	assign widx = l15_address[9:2];
	assign lidx = {l15_address[9:4], 2'b00};
	assign l15_ack = l15_val && !busy && (ack_wait == 2'd0);

	// Word i holds i * 0x01010101 ^ 0xA5A5A5A5
	initial
	begin
		for (int i = 0; i < 256; i++)
			mem[i] = i * 32'h01010101 ^ 32'hA5A5A5A5;
	end

	always @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			busy <= 1'b0;
			ack_wait <= 2'd0;
			resp_wait <= 2'd0;
			l15_resp_val <= 1'b0;
			l15_data_0 <= '0;
			l15_data_1 <= '0;
			l15_returntype <= '0;
			req_count <= 0;
		end
		else
		begin
			if (l15_ack)
			begin
				busy <= 1'b1;
				req_count <= req_count + 1;
				ack_wait <= rnd[1:0]; // Gap before the next ack
				resp_wait <= rnd[3:2];
				l15_data_0 <= {mem[{lidx[7:2], 2'd1}], mem[lidx]}; // Line as it was before a store
				l15_data_1 <= {mem[{lidx[7:2], 2'd3}], mem[{lidx[7:2], 2'd2}]};
				if (l15_rqtype == core_pkg::rq_ifill)
					l15_returntype <= core_pkg::rt_ifill_ret;
				else if (l15_rqtype == core_pkg::rq_store)
					l15_returntype <= core_pkg::rt_st_ack;
				else
					l15_returntype <= core_pkg::rt_load_ret;
				if (l15_rqtype == core_pkg::rq_store)
				begin
					// Store data comes lane replicated
					case (l15_size)
						`CORE_SIZE_B:
							mem[widx][8*l15_address[1:0] +: 8] <= l15_data[8*l15_address[1:0] +: 8];
						`CORE_SIZE_H:
							if (l15_address[1])
								mem[widx][31:16] <= l15_data[31:16];
							else
								mem[widx][15:0] <= l15_data[15:0];
						default: mem[widx] <= l15_data;
					endcase
				end
			end
			else if (l15_val && !busy && ack_wait != 2'd0)
				ack_wait <= ack_wait - 2'd1;
			if (busy && !l15_resp_val)
			begin
				if (resp_wait == 2'd0)
					l15_resp_val <= 1'b1; // Held until req_ack
				else
					resp_wait <= resp_wait - 2'd1;
			end
			if (l15_resp_val && l15_req_ack)
			begin
				l15_resp_val <= 1'b0;
				busy <= 1'b0;
			end
		end
	end

endmodule

// File: sim/tb_core_mem.sv
`include "core_macros.svh"

module tb_core_mem;

	typedef enum {kind_fetch, kind_data, kind_both} kind_e;

	typedef struct {
		string name;
		kind_e kind;
		core_pkg::mem_op_e op;
		logic [`CORE_ADDR_W-1:0] addr; // Data address
		logic [`CORE_ADDR_W-1:0] faddr; // Fetch address
		logic [`CORE_WORD_W-1:0] wdata;
	} entry_t;

	logic clk = 1'b0;
	logic nrst;
	logic fetch_valid;
	logic [`CORE_ADDR_W-1:0] fetch_addr;
	logic fetch_ready;
	logic instr_valid;
	logic [`CORE_WORD_W-1:0] instr;
	logic instr_ready;
	logic lsu_cmd_valid;
	core_pkg::mem_op_e lsu_cmd_op;
	logic [`CORE_ADDR_W-1:0] lsu_cmd_addr;
	logic [`CORE_WORD_W-1:0] lsu_cmd_wdata;
	logic lsu_cmd_ready;
	logic lsu_resp_valid;
	logic [`CORE_WORD_W-1:0] lsu_resp_rdata;
	logic lsu_resp_err;
	logic lsu_resp_ready;
	logic [`CORE_RQTYPE_W-1:0] l15_rqtype;
	logic [`CORE_SIZE_BITS-1:0] l15_size;
	logic [`CORE_ADDR_W-1:0] l15_address;
	logic [`CORE_WORD_W-1:0] l15_data;
	logic l15_val;
	logic l15_ack;
	logic l15_resp_val;
	logic [`CORE_LINE_W-1:0] l15_data_0;
	logic [`CORE_LINE_W-1:0] l15_data_1;
	logic [`CORE_RTYPE_W-1:0] l15_returntype;
	logic l15_req_ack;
	int req_count;

	logic [31:0] rng = 32'd64655;
	logic [31:0] mirror [0:255]; // Expected memory contents
	entry_t tests[$];
	int error_count = 0;
	int pass_count = 0;
	int fail_count = 0;
	bit test_ok;

	core_mem_top core_mem_top_inst (
		.clk (clk), .nrst (nrst),
		.fetch_valid (fetch_valid), .fetch_addr (fetch_addr), .fetch_ready (fetch_ready),
		.instr_valid (instr_valid), .instr (instr), .instr_ready (instr_ready),
		.lsu_cmd_valid (lsu_cmd_valid), .lsu_cmd_op (lsu_cmd_op),
		.lsu_cmd_addr (lsu_cmd_addr), .lsu_cmd_wdata (lsu_cmd_wdata),
		.lsu_cmd_ready (lsu_cmd_ready),
		.lsu_resp_valid (lsu_resp_valid), .lsu_resp_rdata (lsu_resp_rdata),
		.lsu_resp_err (lsu_resp_err), .lsu_resp_ready (lsu_resp_ready),
		.l15_rqtype (l15_rqtype), .l15_size (l15_size), .l15_address (l15_address),
		.l15_data (l15_data), .l15_val (l15_val), .l15_ack (l15_ack),
		.l15_resp_val (l15_resp_val), .l15_data_0 (l15_data_0), .l15_data_1 (l15_data_1),
		.l15_returntype (l15_returntype), .l15_req_ack (l15_req_ack)
	);

	l15_model l15_model_inst (
		.clk (clk), .nrst (nrst), .rnd (rng),
		.l15_rqtype (l15_rqtype), .l15_size (l15_size), .l15_address (l15_address),
		.l15_data (l15_data), .l15_val (l15_val), .l15_ack (l15_ack),
		.l15_resp_val (l15_resp_val), .l15_data_0 (l15_data_0), .l15_data_1 (l15_data_1),
		.l15_returntype (l15_returntype), .l15_req_ack (l15_req_ack),
		.req_count (req_count)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	always @(negedge clk)
		rng <= xorshift(rng); // Readers at this edge still see the old value

	function automatic bit is_misaligned(input core_pkg::mem_op_e op, input logic [31:0] addr);
		if (op inside {core_pkg::mem_lh, core_pkg::mem_lhu, core_pkg::mem_sh})
			return addr[0];
		if (op inside {core_pkg::mem_lw, core_pkg::mem_sw})
			return |addr[1:0];
		return 1'b0;
	endfunction

	// Byte, half or word code by access width
	function automatic logic [`CORE_SIZE_BITS-1:0] access_size(input core_pkg::mem_op_e op);
		case (op)
			core_pkg::mem_lb, core_pkg::mem_lbu, core_pkg::mem_sb: return `CORE_SIZE_B;
			core_pkg::mem_lh, core_pkg::mem_lhu, core_pkg::mem_sh: return `CORE_SIZE_H;
			default: return `CORE_SIZE_W;
		endcase
	endfunction

	// Lane picked by addr[1:0], extended per op
	function automatic logic [31:0] load_value(input core_pkg::mem_op_e op, input logic [31:0] addr);
		logic [31:0] w;
		logic [7:0] b;
		logic [15:0] h;
		w = mirror[addr[9:2]];
		b = w[8*addr[1:0] +: 8];
		h = addr[1] ? w[31:16] : w[15:0];
		case (op)
			core_pkg::mem_lb: return {{24{b[7]}}, b};
			core_pkg::mem_lbu: return {24'd0, b};
			core_pkg::mem_lh: return {{16{h[15]}}, h};
			core_pkg::mem_lhu: return {16'd0, h};
			core_pkg::mem_lw: return w;
			default: return 32'd0; // Stores read back zero
		endcase
	endfunction

	task automatic store_to_mirror(input core_pkg::mem_op_e op, input logic [31:0] addr,
		input logic [31:0] wdata);
		case (op)
			core_pkg::mem_sb: mirror[addr[9:2]][8*addr[1:0] +: 8] = wdata[7:0];
			core_pkg::mem_sh:
				if (addr[1])
					mirror[addr[9:2]][31:16] = wdata[15:0];
				else
					mirror[addr[9:2]][15:0] = wdata[15:0];
			core_pkg::mem_sw: mirror[addr[9:2]] = wdata;
			default: ; // Loads leave memory alone
		endcase
	endtask

	task automatic add_test(input string name, input kind_e kind, input core_pkg::mem_op_e op,
		input logic [31:0] addr, input logic [31:0] faddr, input logic [31:0] wdata);
		entry_t e;
		e.name = name;
		e.kind = kind;
		e.op = op;
		e.addr = addr;
		e.faddr = faddr;
		e.wdata = wdata;
		tests.push_back(e);
	endtask

	task automatic build_table();
		// Fetch of each word in a line
		add_test("fetch_w0", kind_fetch, core_pkg::mem_none, 0, 32'h040, 0);
		add_test("fetch_w1", kind_fetch, core_pkg::mem_none, 0, 32'h044, 0);
		add_test("fetch_w2", kind_fetch, core_pkg::mem_none, 0, 32'h048, 0);
		add_test("fetch_w3", kind_fetch, core_pkg::mem_none, 0, 32'h04C, 0);
		// Store, load back, fetch back
		add_test("sw_word", kind_data, core_pkg::mem_sw, 32'h080, 0, 32'hDEADBEEF);
		add_test("lw_after_sw", kind_data, core_pkg::mem_lw, 32'h080, 0, 0);
		add_test("fetch_after_sw", kind_fetch, core_pkg::mem_none, 0, 32'h080, 0);
		// Narrow loads and stores
		add_test("lb_pos", kind_data, core_pkg::mem_lb, 32'h201, 0, 0);
		add_test("lb_neg", kind_data, core_pkg::mem_lb, 32'h101, 0, 0);
		add_test("lbu_b3", kind_data, core_pkg::mem_lbu, 32'h103, 0, 0);
		add_test("lh_hi", kind_data, core_pkg::mem_lh, 32'h102, 0, 0);
		add_test("lhu_hi", kind_data, core_pkg::mem_lhu, 32'h106, 0, 0);
		add_test("lhu_pos", kind_data, core_pkg::mem_lhu, 32'h200, 0, 0);
		add_test("sb_b2", kind_data, core_pkg::mem_sb, 32'h142, 0, 32'h1234567F);
		add_test("lw_after_sb", kind_data, core_pkg::mem_lw, 32'h140, 0, 0);
		add_test("sh_hi", kind_data, core_pkg::mem_sh, 32'h146, 0, 32'hCAFE8001);
		add_test("lw_after_sh", kind_data, core_pkg::mem_lw, 32'h144, 0, 0);
		// Fill bytes repeat in a word, so lanes differ only after narrow stores
		add_test("lb_after_sb", kind_data, core_pkg::mem_lb, 32'h142, 0, 0);
		add_test("lbu_after_sb", kind_data, core_pkg::mem_lbu, 32'h143, 0, 0);
		add_test("lh_after_sh", kind_data, core_pkg::mem_lh, 32'h146, 0, 0);
		add_test("lhu_after_sh", kind_data, core_pkg::mem_lhu, 32'h144, 0, 0);
		// Misaligned, no cache request
		add_test("lh_misal", kind_data, core_pkg::mem_lh, 32'h181, 0, 0);
		add_test("lw_misal", kind_data, core_pkg::mem_lw, 32'h182, 0, 0);
		add_test("sh_misal", kind_data, core_pkg::mem_sh, 32'h183, 0, 32'h0000BEEF);
		add_test("sw_misal", kind_data, core_pkg::mem_sw, 32'h185, 0, 32'h12345678);
		add_test("lw_unchanged", kind_data, core_pkg::mem_lw, 32'h184, 0, 0);
		// Fetch and data in the same cycle
		add_test("both_lw", kind_both, core_pkg::mem_lw, 32'h3C4, 32'h300, 0);
		add_test("both_sw", kind_both, core_pkg::mem_sw, 32'h3D0, 32'h314, 32'h5A5A0F0F);
		add_test("both_lbu", kind_both, core_pkg::mem_lbu, 32'h3E1, 32'h328, 0);
		add_test("both_lw_sw", kind_both, core_pkg::mem_lw, 32'h3D0, 32'h33C, 0);
		add_test("both_misal", kind_both, core_pkg::mem_lw, 32'h1A2, 32'h200, 0);
		// More traffic under random ready
		add_test("fetch_top", kind_fetch, core_pkg::mem_none, 0, 32'h3FC, 0);
		add_test("lhu_top", kind_data, core_pkg::mem_lhu, 32'h3FE, 0, 0);
		add_test("fetch_low", kind_fetch, core_pkg::mem_none, 0, 32'h004, 0);
	endtask

	task automatic report_mismatch(input string name, input string what,
		input logic [31:0] exp, input logic [31:0] act);
		$display("error %s: %s expected %08h actual %08h", name, what, exp, act);
		error_count++;
		test_ok = 1'b0;
	endtask

	task automatic report_problem(input string name, input string msg);
		$display("%s: %s", name, msg);
		error_count++;
		test_ok = 1'b0;
	endtask

	task automatic run_entry(input entry_t e);
		logic need_f;
		logic need_d;
		logic sent_f;
		logic sent_d;
		logic got_f;
		logic got_d;
		logic hold_f;
		logic hold_d;
		logic exp_err;
		logic held_err;
		logic [31:0] exp_instr;
		logic [31:0] exp_rdata;
		logic [31:0] held_instr;
		logic [31:0] held_rdata;
		logic [`CORE_SIZE_BITS-1:0] exp_size;
		logic [31:0] exp_addr;
		int count_before;
		int exp_reqs;
		int cyc;
		int sent_cyc;
		int tail;
		need_f = (e.kind != kind_data);
		need_d = (e.kind != kind_fetch);
		exp_instr = mirror[e.faddr[9:2]];
		exp_err = is_misaligned(e.op, e.addr);
		exp_rdata = load_value(e.op, e.addr);
		if (need_d && !exp_err)
			store_to_mirror(e.op, e.addr, e.wdata);
		exp_reqs = int'(need_f) + int'(need_d && !exp_err); // One line per fetch or access
		count_before = req_count;
		{sent_f, sent_d, got_f, got_d, hold_f, hold_d, held_err} = '0;
		held_instr = '0;
		held_rdata = '0;
		cyc = 0;
		sent_cyc = 0;
		tail = 0;
		test_ok = 1'b1;
		while (tail < 3)
		begin
			@(negedge clk);
			cyc++;
			if (hold_f)
				assert (instr_valid && instr == held_instr)
				else report_problem(e.name, "instruction changed or dropped while stalled");
			if (hold_d)
				assert (lsu_resp_valid && lsu_resp_rdata == held_rdata && lsu_resp_err == held_err)
				else report_problem(e.name, "load/store response changed or dropped while stalled");
			if (need_d && exp_err && sent_d && cyc == sent_cyc + 1)
				assert (lsu_resp_valid)
				else report_problem(e.name, "misaligned command not answered on the next cycle");
			// Request fields on the cycle the cache takes them
			if (l15_val && l15_ack)
			begin
				if (l15_rqtype == core_pkg::rq_ifill)
				begin
					exp_size = `CORE_SIZE_LINE;
					exp_addr = {e.faddr[31:4], 4'h0}; // Line aligned
				end
				else
				begin
					exp_size = access_size(e.op);
					exp_addr = e.addr;
				end
				assert (l15_size == exp_size)
				else report_mismatch(e.name, "request size", 32'(exp_size), 32'(l15_size));
				assert (l15_address == exp_addr)
				else report_mismatch(e.name, "request address", exp_addr, l15_address);
			end
			hold_f = 1'b0;
			hold_d = 1'b0;
			instr_ready = |rng[5:4]; // High three cycles in four
			lsu_resp_ready = |rng[9:8];
			if (instr_valid)
			begin
				assert (need_f && !got_f) else report_problem(e.name, "unexpected extra instruction");
				if (instr_ready)
				begin
					got_f = 1'b1; // Taken at the next rising edge
					assert (instr == exp_instr) else report_mismatch(e.name, "instr", exp_instr, instr);
				end
				else
				begin
					hold_f = 1'b1;
					held_instr = instr;
				end
			end
			if (lsu_resp_valid)
			begin
				assert (need_d && !got_d) else report_problem(e.name, "unexpected extra load/store response");
				if (lsu_resp_ready)
				begin
					got_d = 1'b1;
					assert (lsu_resp_err == exp_err)
					else report_mismatch(e.name, "err", 32'(exp_err), 32'(lsu_resp_err));
					if (!exp_err)
						assert (lsu_resp_rdata == exp_rdata)
						else report_mismatch(e.name, "rdata", exp_rdata, lsu_resp_rdata);
				end
				else
				begin
					hold_d = 1'b1;
					held_rdata = lsu_resp_rdata;
					held_err = lsu_resp_err;
				end
			end
			fetch_valid = 1'b0; // Commands last one cycle
			lsu_cmd_valid = 1'b0;
			if (need_f && !sent_f && fetch_ready)
			begin
				fetch_valid = 1'b1;
				fetch_addr = e.faddr;
				sent_f = 1'b1;
			end
			if (need_d && !sent_d && lsu_cmd_ready)
			begin
				lsu_cmd_valid = 1'b1;
				lsu_cmd_op = e.op;
				lsu_cmd_addr = e.addr;
				lsu_cmd_wdata = e.wdata;
				sent_d = 1'b1;
				sent_cyc = cyc;
			end
			if ((got_f || !need_f) && (got_d || !need_d))
				tail++; // Watch a little longer for duplicates
		end
		assert (req_count - count_before == exp_reqs)
		else report_mismatch(e.name, "cache requests", exp_reqs, req_count - count_before);
		if (test_ok)
			pass_count++;
		else
			fail_count++;
		$display("test %s: %s", e.name, test_ok ? "pass" : "fail");
	endtask

	initial
	begin
		nrst = 1'b0;
		fetch_valid = 1'b0;
		fetch_addr = '0;
		instr_ready = 1'b0;
		lsu_cmd_valid = 1'b0;
		lsu_cmd_op = core_pkg::mem_none;
		lsu_cmd_addr = '0;
		lsu_cmd_wdata = '0;
		lsu_resp_ready = 1'b0;
		for (int i = 0; i < 256; i++)
			mirror[i] = i * 32'h01010101 ^ 32'hA5A5A5A5; // Same fill as the cache model
		build_table();
		repeat (4) @(negedge clk);
		nrst = 1'b1;
		foreach (tests[i])
			run_entry(tests[i]);
		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			tests.size(), pass_count, fail_count, error_count);
		if (fail_count == 0 && error_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// 200 cycles per table entry
	initial
	begin
		@(posedge nrst);
		repeat (tests.size() * 200) @(posedge clk);
		$display("timeout: tests did not finish within %0d cycles", tests.size() * 200);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: files.f
+incdir+logic
logic/core_pkg.sv
logic/l15_if.sv
logic/fetch_unit.sv
logic/lsu.sv
logic/l15_arbiter.sv
logic/core_mem_top.sv
sim/l15_model.sv
sim/tb_core_mem.sv

// File: Makefile
# Verilator build and run of the memory side testbench

VERILATOR ?= verilator
TOP ?= tb_core_mem
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FILELIST ?= files.f
VFLAGS ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard logic/*.svh)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
